// File: ooo_exec_pkg.sv
//****************************************
// shared types and credit limits for the
// out-of-order execute stage
//****************************************
package ooo_exec_pkg;

  // credits held by dispatch, one pool per unit
  localparam int ALU_CREDITS = 2;
  localparam int MUL_CREDITS = 1;
  localparam int DIV_CREDITS = 1;

  // commit buffer slots seen by the writeback arbiter
  localparam int COMMIT_CREDITS = 4;
  localparam int COMMIT_CNT_W   = $clog2(COMMIT_CREDITS + 1);

  // alu result queue sizing
  localparam int ALU_PTR_W = (ALU_CREDITS > 1) ? $clog2(ALU_CREDITS) : 1;
  localparam int ALU_CNT_W = $clog2(ALU_CREDITS + 1);

  typedef logic [31:0] word_t;
  typedef logic [3:0]  tag_t;

  typedef enum logic [1:0] {
    FU_ALU = 2'd0,
    FU_MUL = 2'd1,
    FU_DIV = 2'd2
  } fu_t;

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9
  } aluop_t;

  // high picks the upper product word, or the remainder for divides
  typedef struct packed {
    logic high;
    logic rs1_signed;
    logic rs2_signed;
    logic spare;
  } md_ctrl_t;

  typedef union packed {
    aluop_t   alu;
    md_ctrl_t md;
  } op_ctrl_u;

  typedef struct packed {
    fu_t      fu;
    op_ctrl_u ctrl;
    tag_t     tag;
    word_t    rs1_data;
    word_t    rs2_data;
  } issue_t;

  typedef struct packed {
    tag_t  tag;
    word_t wdata;
  } result_t;

  typedef struct packed {
    logic alu;
    logic mul;
    logic div;
  } fu_vec_t;

endpackage

// File: arith_unit.sv
//****************************************
// arithmetic unit: single-cycle RV32I alu
// feeding a small result queue
//****************************************
`timescale 1ns/100ps

module arith_unit import ooo_exec_pkg::*; (
  input  logic    CLK,
  input  logic    nRST,
  input  logic    start,
  input  issue_t  op,
  output logic    req,
  output result_t res,
  input  logic    grant
);

  word_t                a;
  word_t                b;
  word_t                alu_out;
  result_t              fifo_mem [ALU_CREDITS];
  logic [ALU_PTR_W-1:0] wr_ptr;
  logic [ALU_PTR_W-1:0] rd_ptr;
  logic [ALU_CNT_W-1:0] count;

  function automatic logic [ALU_PTR_W-1:0] ptr_inc(input logic [ALU_PTR_W-1:0] p);
    return (p == ALU_PTR_W'(ALU_CREDITS - 1)) ? '0 : p + 1'b1;
  endfunction

  assign a = op.rs1_data;
  assign b = op.rs2_data;

  // shift amount from the low five bits only
  always_comb begin
    case (op.ctrl.alu)
      ADD:     alu_out = a + b;
      SUB:     alu_out = a - b;
      AND:     alu_out = a & b;
      OR:      alu_out = a | b;
      XOR:     alu_out = a ^ b;
      SLL:     alu_out = a << b[4:0];
      SRL:     alu_out = a >> b[4:0];
      SRA:     alu_out = word_t'($signed(a) >>> b[4:0]);
      SLT:     alu_out = {31'b0, $signed(a) < $signed(b)};
      SLTU:    alu_out = {31'b0, a < b};
      default: alu_out = '0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      fifo_mem[wr_ptr] <= '{tag: op.tag, wdata: alu_out};
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (start) wr_ptr <= ptr_inc(wr_ptr);
      if (grant) rd_ptr <= ptr_inc(rd_ptr);
      case ({start, grant})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign req = (count != '0);
  assign res = fifo_mem[rd_ptr];

endmodule

// File: multiply_unit.sv
//****************************************
// iterative multiplier, 32x8 per step,
// sign applied on the magnitude product
//****************************************
`timescale 1ns/100ps

module multiply_unit import ooo_exec_pkg::*; (
  input  logic    CLK,
  input  logic    nRST,
  input  logic    start,
  input  issue_t  op,
  output logic    req,
  output result_t res,
  input  logic    grant
);

  localparam int MUL_STEPS = 4;

  md_ctrl_t                     md;
  logic                         a_neg;
  logic                         b_neg;
  word_t                        a_mag;
  word_t                        b_mag;
  logic [63:0]                  cand_in;
  logic [63:0]                  acc_in;
  logic [7:0]                   byte_in;
  logic [63:0]                  product;
  logic                         busy;
  logic                         done;
  logic [$clog2(MUL_STEPS)-1:0] step;
  logic [63:0]                  mcand;
  logic [63:0]                  acc;
  word_t                        mplier;
  logic                         neg;
  logic                         high;
  tag_t                         tag;

  assign md    = op.ctrl.md;
  assign a_neg = md.rs1_signed & op.rs1_data[31];
  assign b_neg = md.rs2_signed & op.rs2_data[31];
  assign a_mag = a_neg ? -op.rs1_data : op.rs1_data;
  assign b_mag = b_neg ? -op.rs2_data : op.rs2_data;

  // start edge already takes the first partial product
  assign cand_in = start ? {32'b0, a_mag} : mcand;
  assign byte_in = start ? b_mag[7:0] : mplier[7:0];
  assign acc_in  = start ? '0 : acc;

  always_ff @(posedge CLK) begin
    if (start || busy) begin
      acc    <= acc_in + cand_in * {56'b0, byte_in};
      mcand  <= cand_in << 8;
      mplier <= (start ? b_mag : mplier) >> 8;
    end
    if (start) begin
      neg  <= a_neg ^ b_neg;
      high <= md.high;
      tag  <= op.tag;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy <= 1'b0;
      done <= 1'b0;
      step <= '0;
    end else begin
      if (start) begin
        busy <= 1'b1;
        step <= 1;
      end else if (busy) begin
        step <= step + 1'b1;
        if (step == $bits(step)'(MUL_STEPS - 1)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
      if (grant) done <= 1'b0;
    end
  end

  // result held until the arbiter takes it
  assign product   = neg ? -acc : acc;
  assign req       = done;
  assign res.tag   = tag;
  assign res.wdata = high ? product[63:32] : product[31:0];

endmodule

// File: divide_unit.sv
//****************************************
// iterative restoring divider with the
// RISC-V divide-by-zero and overflow rules
//****************************************
`timescale 1ns/100ps

module divide_unit import ooo_exec_pkg::*; (
  input  logic    CLK,
  input  logic    nRST,
  input  logic    start,
  input  issue_t  op,
  output logic    req,
  output result_t res,
  input  logic    grant
);

  localparam int DIV_STEPS = 32;

  md_ctrl_t                     md;
  logic                         a_neg;
  logic                         b_neg;
  logic                         b_zero;
  word_t                        a_mag;
  word_t                        b_mag;
  word_t                        rem_in;
  word_t                        quo_in;
  word_t                        dvsr_in;
  logic [32:0]                  shifted;
  logic [32:0]                  diff;
  logic                         fits;
  word_t                        rem_next;
  word_t                        rem;
  word_t                        quo;
  word_t                        dvsr;
  word_t                        result;
  logic                         busy;
  logic                         fix;
  logic                         done;
  logic [$clog2(DIV_STEPS)-1:0] step;
  logic                         q_neg;
  logic                         r_neg;
  logic                         high;
  tag_t                         tag;

  assign md     = op.ctrl.md;
  assign a_neg  = md.rs1_signed & op.rs1_data[31];
  assign b_neg  = md.rs2_signed & op.rs2_data[31];
  assign b_zero = (op.rs2_data == '0);
  assign a_mag  = a_neg ? -op.rs1_data : op.rs1_data;
  assign b_mag  = b_neg ? -op.rs2_data : op.rs2_data;

  // first step runs on the start edge straight from the operands
  assign rem_in  = start ? '0 : rem;
  assign quo_in  = start ? a_mag : quo;
  assign dvsr_in = start ? b_mag : dvsr;

  // zero divisor always fits, leaving all ones and the dividend
  assign shifted  = {rem_in, quo_in[31]};
  assign diff     = shifted - {1'b0, dvsr_in};
  assign fits     = (shifted >= {1'b0, dvsr_in});
  assign rem_next = fits ? diff[31:0] : shifted[31:0];

  always_ff @(posedge CLK) begin
    if (start || busy) begin
      rem <= rem_next;
      quo <= {quo_in[30:0], fits};
    end
    if (start) begin
      dvsr  <= b_mag;
      // all-ones quotient of a zero divisor keeps its sign
      q_neg <= (a_neg ^ b_neg) & ~b_zero;
      r_neg <= a_neg;
      high  <= md.high;
      tag   <= op.tag;
    end
    if (fix) begin
      if (high) result <= r_neg ? -rem : rem;
      else      result <= q_neg ? -quo : quo;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy <= 1'b0;
      fix  <= 1'b0;
      done <= 1'b0;
      step <= '0;
    end else begin
      if (start) begin
        busy <= 1'b1;
        step <= 1;
      end else if (busy) begin
        step <= step + 1'b1;
        if (step == $bits(step)'(DIV_STEPS - 1)) begin
          busy <= 1'b0;
          fix  <= 1'b1;
        end
      end
      if (fix) begin
        fix  <= 1'b0;
        done <= 1'b1;
      end
      if (grant) done <= 1'b0;
    end
  end

  assign req       = done;
  assign res.tag   = tag;
  assign res.wdata = result;

endmodule

// File: writeback_arbiter.sv
//****************************************
// round-robin writeback arbiter gated by
// commit buffer credits
//****************************************
`timescale 1ns/100ps

module writeback_arbiter import ooo_exec_pkg::*; (
  input  logic    CLK,
  input  logic    nRST,
  input  fu_vec_t req,
  input  result_t res_alu,
  input  result_t res_mul,
  input  result_t res_div,
  output fu_vec_t grant,
  output logic    wb_valid,
  output result_t wb,
  output fu_vec_t credit_return,
  input  logic    commit_credit_return
);

  logic [2:0]              req_bits;
  logic [2:0]              gnt_bits;
  logic [1:0]              last_idx;
  logic [1:0]              rr_idx;
  logic [1:0]              win_idx;
  logic [COMMIT_CNT_W-1:0] credit_cnt;
  logic                    granted;
  result_t                 win_res;

  // alu at bit 0, mul bit 1, div bit 2
  assign req_bits = {req.div, req.mul, req.alu};

  // search starts one past the last winner
  always_comb begin
    gnt_bits = '0;
    rr_idx   = last_idx;
    if (credit_cnt != '0) begin
      for (int i = 1; i <= 3; i++) begin
        rr_idx = 2'((int'(last_idx) + i) % 3);
        if (req_bits[rr_idx] && (gnt_bits == '0)) gnt_bits[rr_idx] = 1'b1;
      end
    end
  end

  assign granted = |gnt_bits;
  assign grant   = '{alu: gnt_bits[0], mul: gnt_bits[1], div: gnt_bits[2]};
  assign win_idx = gnt_bits[2] ? 2'd2 : (gnt_bits[1] ? 2'd1 : 2'd0);
  assign win_res = gnt_bits[2] ? res_div : (gnt_bits[1] ? res_mul : res_alu);

  always_ff @(posedge CLK) begin
    if (granted) wb <= win_res;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wb_valid      <= 1'b0;
      credit_return <= '0;
      last_idx      <= 2'd2;
      credit_cnt    <= COMMIT_CNT_W'(COMMIT_CREDITS);
    end else begin
      wb_valid      <= granted;
      credit_return <= grant;
      if (granted) last_idx <= win_idx;
      case ({granted, commit_credit_return})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule

// File: ooo_execute_stage.sv
//****************************************
// execute stage: alu, multiply and divide
// units sharing one credited writeback bus
//****************************************
`timescale 1ns/100ps

module ooo_execute_stage import ooo_exec_pkg::*; (
  input  logic    CLK,
  input  logic    nRST,
  input  logic    issue_valid,
  input  issue_t  issue,
  output fu_vec_t credit_return,
  output logic    wb_valid,
  output result_t wb,
  input  logic    commit_credit_return
);

  fu_vec_t start;
  fu_vec_t unit_req;
  fu_vec_t unit_grant;
  logic    alu_req;
  logic    mul_req;
  logic    div_req;
  result_t res_alu;
  result_t res_mul;
  result_t res_div;

  // one start pulse per issue, picked by the target unit
  always_comb begin
    start = '0;
    if (issue_valid) begin
      case (issue.fu)
        FU_ALU:  start.alu = 1'b1;
        FU_MUL:  start.mul = 1'b1;
        FU_DIV:  start.div = 1'b1;
        default: start = '0;
      endcase
    end
  end

  arith_unit u_arith (
    .CLK   (CLK),
    .nRST  (nRST),
    .start (start.alu),
    .op    (issue),
    .req   (alu_req),
    .res   (res_alu),
    .grant (unit_grant.alu)
  );

  multiply_unit u_mul (
    .CLK   (CLK),
    .nRST  (nRST),
    .start (start.mul),
    .op    (issue),
    .req   (mul_req),
    .res   (res_mul),
    .grant (unit_grant.mul)
  );

  divide_unit u_div (
    .CLK   (CLK),
    .nRST  (nRST),
    .start (start.div),
    .op    (issue),
    .req   (div_req),
    .res   (res_div),
    .grant (unit_grant.div)
  );

  assign unit_req = '{alu: alu_req, mul: mul_req, div: div_req};

  writeback_arbiter u_wb_arb (
    .CLK                  (CLK),
    .nRST                 (nRST),
    .req                  (unit_req),
    .res_alu              (res_alu),
    .res_mul              (res_mul),
    .res_div              (res_div),
    .grant                (unit_grant),
    .wb_valid             (wb_valid),
    .wb                   (wb),
    .credit_return        (credit_return),
    .commit_credit_return (commit_credit_return)
  );

endmodule

// File: tb_ooo_execute_stage.sv
//****************************************
// testbench for the execute stage: random
// and corner operations checked by tag
//****************************************
`timescale 1ns/100ps

module tb_ooo_execute_stage import ooo_exec_pkg::*; ();

  localparam int MAX_CYCLES = 20000;

  logic    CLK;
  logic    nRST;
  logic    issue_valid;
  issue_t  issue;
  fu_vec_t credit_return;
  logic    wb_valid;
  result_t wb;
  logic    commit_credit_return;

  int    seed = 32'hc666_aeb4;
  int    cycle = 0;
  int    value_errs = 0;
  int    proto_errs = 0;
  int    cred [3];
  bit    outstanding [16];
  word_t exp_data [16];
  fu_t   exp_fu [16];
  string exp_name [16];
  int    n_outstanding = 0;
  int    tag_ptr = 0;
  int    last_tag = 0;
  int    occupancy = 0;
  int    due_q [$];
  bit    withhold = 1'b0;
  bit    div_in_flight = 1'b0;
  int    div_tag = 0;
  bit    alu_passed_div = 1'b0;
  word_t edges [4] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000};
  string mul_names [4] = '{"mul", "mulh", "mulhsu", "mulhu"};
  string div_names [4] = '{"div", "divu", "rem", "remu"};

  ooo_execute_stage u_dut (
    .CLK                  (CLK),
    .nRST                 (nRST),
    .issue_valid          (issue_valid),
    .issue                (issue),
    .credit_return        (credit_return),
    .wb_valid             (wb_valid),
    .wb                   (wb),
    .commit_credit_return (commit_credit_return)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle = cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d operations in flight", cycle, n_outstanding);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic word_t alu_ref(input aluop_t op, input word_t a, input word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ADD:     return a + b;
      SUB:     return a + ~b + 32'h1;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << sh;
      SRL:     return a >> sh;
      // vacated upper bits take the sign
      SRA:     return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      // flipped sign bits turn a signed compare into an unsigned one
      SLT:     return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
      SLTU:    return {31'b0, a < b};
      default: return 32'h0;
    endcase
  endfunction

  function automatic word_t mul_ref(input md_ctrl_t c, input word_t a, input word_t b);
    logic [63:0] ax;
    logic [63:0] bx;
    logic [63:0] p;
    ax = {(c.rs1_signed ? {32{a[31]}} : 32'h0), a};
    bx = {(c.rs2_signed ? {32{b[31]}} : 32'h0), b};
    p  = ax * bx;
    return c.high ? p[63:32] : p[31:0];
  endfunction

  function automatic word_t div_ref(input md_ctrl_t c, input word_t a, input word_t b);
    word_t q;
    word_t r;
    if (b == 32'h0) begin
      q = 32'hffff_ffff;
      r = a;
    end else if (c.rs1_signed && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      q = a;
      r = 32'h0;
    end else if (c.rs1_signed) begin
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    return c.high ? r : q;
  endfunction

  function automatic word_t expected_result(input fu_t fu, input op_ctrl_u c,
                                            input word_t a, input word_t b);
    case (fu)
      FU_ALU:  return alu_ref(c.alu, a, b);
      FU_MUL:  return mul_ref(c.md, a, b);
      default: return div_ref(c.md, a, b);
    endcase
  endfunction

  function automatic op_ctrl_u md_ctrl(input bit high, input bit s1, input bit s2);
    op_ctrl_u c;
    c.md = '{high: high, rs1_signed: s1, rs2_signed: s2, spare: 1'b0};
    return c;
  endfunction

  function automatic op_ctrl_u alu_ctrl(input aluop_t op);
    op_ctrl_u c;
    c.alu = op;
    return c;
  endfunction

  function automatic fu_vec_t fu_bit(input fu_t fu);
    fu_vec_t v;
    v = '0;
    case (fu)
      FU_ALU:  v.alu = 1'b1;
      FU_MUL:  v.mul = 1'b1;
      default: v.div = 1'b1;
    endcase
    return v;
  endfunction

  function automatic word_t rand_word();
    return word_t'($random(seed));
  endfunction

  // rotating search keeps recently used tags idle for a while
  function automatic int free_tag();
    int k;
    for (int i = 0; i < 16; i++) begin
      k = (tag_ptr + i) % 16;
      if (!outstanding[k]) begin
        tag_ptr = (k + 1) % 16;
        return k;
      end
    end
    return -1;
  endfunction

  task automatic check_writeback();
    int t;
    t = int'(wb.tag);
    assert (outstanding[t]) else begin
      $display("writeback for tag %0d which is not outstanding", t);
      proto_errs++;
    end
    if (outstanding[t]) begin
      assert (wb.wdata == exp_data[t]) else begin
        $display("FAIL %s: expected %h, actual %h", exp_name[t], exp_data[t], wb.wdata);
        value_errs++;
      end
      assert (credit_return == fu_bit(exp_fu[t])) else begin
        $display("FAIL %s credit_return: expected %b, actual %b", exp_name[t],
                 fu_bit(exp_fu[t]), credit_return);
        value_errs++;
      end
      if (div_in_flight && exp_fu[t] == FU_ALU) alu_passed_div = 1'b1;
      if (div_in_flight && t == div_tag) div_in_flight = 1'b0;
      outstanding[t] = 1'b0;
      n_outstanding--;
    end
    if (credit_return.alu) cred[0]++;
    if (credit_return.mul) cred[1]++;
    if (credit_return.div) cred[2]++;
    occupancy++;
    assert (occupancy <= COMMIT_CREDITS) else begin
      $display("commit buffer overrun, %0d results held at cycle %0d", occupancy, cycle);
      proto_errs++;
    end
    due_q.push_back(cycle + int'($unsigned($random(seed)) % 4));
  endtask

  // one clock: sample the outputs mid-cycle, then drive commit
  task automatic step_cycle();
    @(negedge CLK);
    issue_valid = 1'b0;
    commit_credit_return = 1'b0;
    if (wb_valid) begin
      check_writeback();
    end else begin
      assert (credit_return == '0) else begin
        $display("credit_return pulsed without a writeback at cycle %0d", cycle);
        proto_errs++;
      end
    end
    if (!withhold && due_q.size() > 0 && due_q[0] <= cycle) begin
      void'(due_q.pop_front());
      commit_credit_return = 1'b1;
      occupancy--;
    end
  endtask

  task automatic try_issue(input fu_t fu, input op_ctrl_u c, input word_t a, input word_t b,
                           input string name, output bit ok);
    int t;
    ok = 1'b0;
    t = free_tag();
    if (cred[int'(fu)] > 0 && t >= 0) begin
      cred[int'(fu)]--;
      outstanding[t] = 1'b1;
      n_outstanding++;
      exp_fu[t]   = fu;
      exp_name[t] = name;
      exp_data[t] = expected_result(fu, c, a, b);
      last_tag    = t;
      issue.fu       = fu;
      issue.ctrl     = c;
      issue.tag      = tag_t'(t);
      issue.rs1_data = a;
      issue.rs2_data = b;
      issue_valid    = 1'b1;
      ok = 1'b1;
    end
  endtask

  task automatic issue_op(input fu_t fu, input op_ctrl_u c, input word_t a, input word_t b,
                          input string name);
    bit ok;
    try_issue(fu, c, a, b, name, ok);
    while (!ok) begin
      step_cycle();
      try_issue(fu, c, a, b, name, ok);
    end
    step_cycle();
  endtask

  task automatic drain();
    while (n_outstanding > 0) step_cycle();
  endtask

  initial begin
    aluop_t   op;
    op_ctrl_u c;
    word_t    a;
    word_t    b;
    bit       ok;
    nRST = 1'b0;
    issue_valid = 1'b0;
    issue = '0;
    commit_credit_return = 1'b0;
    cred[0] = ALU_CREDITS;
    cred[1] = MUL_CREDITS;
    cred[2] = DIV_CREDITS;
    repeat (3) @(negedge CLK);
    nRST = 1'b1;
    assert (!wb_valid && credit_return == '0) else begin
      $display("wb_valid or credit_return high right after reset");
      proto_errs++;
    end

    for (int k = 0; k <= 9; k++) begin
      op = aluop_t'(k);
      for (int i = 0; i < 6; i++) begin
        issue_op(FU_ALU, alu_ctrl(op), rand_word(), rand_word(), $sformatf("alu %s", op.name()));
      end
    end

    // edge operand pairs first, then random ones
    for (int k = 0; k < 4; k++) begin
      c = md_ctrl(k != 0, k == 1 || k == 2, k == 1);
      for (int i = 0; i < 20; i++) begin
        a = (i < 16) ? edges[i / 4] : rand_word();
        b = (i < 16) ? edges[i % 4] : rand_word();
        issue_op(FU_MUL, c, a, b, mul_names[k]);
      end
    end

    for (int k = 0; k < 4; k++) begin
      c = md_ctrl(k >= 2, k == 0 || k == 2, k == 0 || k == 2);
      for (int i = 0; i < 20; i++) begin
        a = (i < 16) ? edges[i / 4] : rand_word();
        b = (i < 16) ? edges[i % 4] : rand_word();
        issue_op(FU_DIV, c, a, b, div_names[k]);
      end
    end
    drain();

    // commit back-pressure
    withhold = 1'b1;
    for (int i = 0; i < 60; i++) begin
      if (i % 2 == 0) try_issue(FU_ALU, alu_ctrl(ADD), rand_word(), rand_word(), "stall add", ok);
      else try_issue(FU_MUL, md_ctrl(0, 0, 0), rand_word(), rand_word(), "stall mul", ok);
      step_cycle();
    end
    assert (occupancy == COMMIT_CREDITS) else begin
      $display("FAIL commit stall: expected %0d, actual %0d", COMMIT_CREDITS, occupancy);
      value_errs++;
    end
    withhold = 1'b0;
    drain();

    // short alu ops overtake a long divide
    issue_op(FU_DIV, md_ctrl(0, 1, 1), rand_word(), 32'h7, "ooo div");
    div_tag = last_tag;
    div_in_flight = 1'b1;
    for (int i = 0; i < 6; i++) begin
      issue_op(FU_ALU, alu_ctrl(XOR), rand_word(), rand_word(), "ooo alu");
    end
    drain();
    assert (alu_passed_div) else begin
      $display("no alu result reached writeback ahead of the divide");
      proto_errs++;
    end

    repeat (8) step_cycle();
    $display("errors: %0d value, %0d protocol, after %0d cycles", value_errs, proto_errs, cycle);
    if (value_errs + proto_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: filelist.f
ooo_exec_pkg.sv
arith_unit.sv
multiply_unit.sv
divide_unit.sv
writeback_arbiter.sv
ooo_execute_stage.sv
tb_ooo_execute_stage.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing
SIM_FLAGS   = --binary --timing --assert
RTL_TOP     = ooo_execute_stage
TB_TOP      = tb_ooo_execute_stage
FILELIST    = filelist.f
SIM_BIN     = obj_dir/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
